// ==== files.f ====
hw/l2_defs_pkg.sv
hw/sync_fifo.sv
hw/l2_pending_miss_cam.sv
hw/l2_axi_bus_interface.sv
hw/l2_miss_handler.sv
tests/axi_memory_model.sv
tests/l2_miss_handler_tb.sv

// ==== hw/l2_axi_bus_interface.sv ====
module l2_axi_bus_interface
	import l2_defs_pkg::*;
	(input clk,
	input reset,

	// System memory
	output axi_req_t axi_bus_req,
	input axi_resp_t axi_bus_resp,

	// From the read stage
	input l2req_packet_t l2r_request,
	input logic l2r_cache_hit,
	input logic l2r_is_l2_fill,
	input logic l2r_needs_writeback,
	input l2_tag_t l2r_writeback_tag,
	input cache_line_data_t l2r_data,

	// Pending miss table
	input logic duplicate_request,
	output logic enqueue_load_request,

	// Back to the cache pipeline for reissue
	output l2req_packet_t l2bi_request,
	output cache_line_data_t l2bi_data_from_memory,
	output logic l2bi_stall,
	output logic l2bi_ready,
	output logic l2bi_collided_miss,

	output logic perf_l2_writeback);

	typedef enum logic [2:0] {
		idle,
		write_issue_address,
		write_transfer,
		read_issue_address,
		read_transfer,
		read_complete
	} bus_state_e;

	// An evicted line and where it lives in memory
	typedef struct packed {
		cache_line_index_t address;
		cache_line_data_t data;
	} writeback_entry_t;

	// A missed request and whether another miss already fetches its line
	typedef struct packed {
		logic collided;
		l2req_packet_t packet;
	} load_entry_t;

	writeback_entry_t writeback_in;
	writeback_entry_t writeback_head;
	load_entry_t load_in;
	load_entry_t load_head;
	logic enqueue_writeback_request;
	logic writeback_complete;
	logic writeback_queue_empty;
	logic writeback_queue_almost_full;
	logic load_queue_empty;
	logic load_queue_almost_full;
	logic full_line_store;
	logic wait_write_response;
	bus_state_e state;
	bus_state_e state_nxt;
	logic [beat_idx_width - 1:0] burst_offset;
	logic [beat_idx_width - 1:0] burst_offset_nxt;
	logic [axi_data_width - 1:0] write_word;
	logic [axi_data_width - 1:0] load_buffer [burst_beats];

	// A dirty line leaves the cache either when a flush hits it or when a fill
	// replaces it
	assign enqueue_writeback_request = l2r_request.valid && l2r_needs_writeback
		&& ((l2r_request.packet_type == l2req_flush && l2r_cache_hit) || l2r_is_l2_fill);

	// Only real misses of memory operations go to system memory. Fills are the
	// reissued results and never miss again here
	assign enqueue_load_request = l2r_request.valid && !l2r_cache_hit && !l2r_is_l2_fill
		&& (l2r_request.packet_type == l2req_load
		|| l2r_request.packet_type == l2req_store
		|| l2r_request.packet_type == l2req_load_sync
		|| l2r_request.packet_type == l2req_store_sync);

	// The victim keeps the set index of the request that displaced it
	assign writeback_in.address = {l2r_writeback_tag, l2r_request.address.set_idx};
	assign writeback_in.data = l2r_data;
	assign load_in.collided = duplicate_request;
	assign load_in.packet = l2r_request;

	// Counts every writeback the queue takes in
	assign perf_l2_writeback = enqueue_writeback_request;

	sync_fifo #(.data_width($bits(writeback_entry_t)),
		.num_entries(request_queue_length),
		.almost_full_threshold(request_queue_length - l2req_latency)) writeback_queue(
		.clk(clk),
		.reset(reset),
		.flush_en(1'b0),
		.enqueue_en(enqueue_writeback_request),
		.value_i(writeback_in),
		.dequeue_en(writeback_complete),
		.value_o(writeback_head),
		.empty(writeback_queue_empty),
		.full(),
		.almost_full(writeback_queue_almost_full),
		.almost_empty());

	sync_fifo #(.data_width($bits(load_entry_t)),
		.num_entries(request_queue_length),
		.almost_full_threshold(request_queue_length - l2req_latency)) load_queue(
		.clk(clk),
		.reset(reset),
		.flush_en(1'b0),
		.enqueue_en(enqueue_load_request),
		.value_i(load_in),
		.dequeue_en(l2bi_ready),
		.value_o(load_head),
		.empty(load_queue_empty),
		.full(),
		.almost_full(load_queue_almost_full),
		.almost_empty());

	// The head of the load queue is the request being serviced
	assign l2bi_request = load_head.packet;
	assign l2bi_collided_miss = load_head.collided;

	// Raised early enough that packets still in the upper pipeline fit
	assign l2bi_stall = load_queue_almost_full || writeback_queue_almost_full;

	// A store that overwrites the whole line needs no data from memory
	assign full_line_store = l2bi_request.packet_type == l2req_store
		&& l2bi_request.store_mask == {cache_line_bytes{1'b1}};

	// Write beats go out most significant word first
	assign write_word = writeback_head.data[(burst_beats - 1 - burst_offset) * axi_data_width
		+: axi_data_width];

	// The first beat read lands in the most significant word of the line
	for (genvar i = 0; i < burst_beats; i++)
	begin : load_lane_gen
		assign l2bi_data_from_memory[i * axi_data_width +: axi_data_width]
			= load_buffer[burst_beats - 1 - i];
	end

	always_comb
	begin
		state_nxt = state;
		burst_offset_nxt = burst_offset;
		writeback_complete = 1'b0;
		l2bi_ready = 1'b0;

		axi_bus_req = '0;
		axi_bus_req.awaddr = {writeback_head.address, {offset_width{1'b0}}};
		axi_bus_req.araddr = {l2bi_request.address.tag, l2bi_request.address.set_idx,
			{offset_width{1'b0}}};

		// Length encodes beats minus one
		axi_bus_req.awlen = axi_len_width'(burst_beats - 1);
		axi_bus_req.arlen = axi_len_width'(burst_beats - 1);
		axi_bus_req.wdata = write_word;
		axi_bus_req.bready = 1'b1;

		unique case (state)
			idle:
			begin
				// Writebacks go first so a load cannot read stale memory for a
				// line whose dirty copy is still queued. A new write address
				// also waits for the response of the previous burst
				if (!writeback_queue_empty)
				begin
					if (!wait_write_response)
						state_nxt = write_issue_address;
				end
				else if (!load_queue_empty)
				begin
					// A collided miss gets its line from the burst already
					// started, and a full line store has nothing to read
					if (l2bi_collided_miss || full_line_store)
						state_nxt = read_complete;
					else
						state_nxt = read_issue_address;
				end
			end

			write_issue_address:
			begin
				axi_bus_req.awvalid = 1'b1;
				burst_offset_nxt = '0;
				if (axi_bus_resp.awready)
					state_nxt = write_transfer;
			end

			write_transfer:
			begin
				axi_bus_req.wvalid = 1'b1;
				if (burst_offset == beat_idx_width'(burst_beats - 1))
					axi_bus_req.wlast = 1'b1;

				if (axi_bus_resp.wready)
				begin
					// Last beat accepted, so the line can leave the queue
					if (burst_offset == beat_idx_width'(burst_beats - 1))
					begin
						writeback_complete = 1'b1;
						state_nxt = idle;
					end

					burst_offset_nxt = burst_offset + 1'b1;
				end
			end

			read_issue_address:
			begin
				axi_bus_req.arvalid = 1'b1;
				burst_offset_nxt = '0;
				if (axi_bus_resp.arready)
					state_nxt = read_transfer;
			end

			read_transfer:
			begin
				axi_bus_req.rready = 1'b1;
				if (axi_bus_resp.rvalid)
				begin
					if (burst_offset == beat_idx_width'(burst_beats - 1))
						state_nxt = read_complete;

					burst_offset_nxt = burst_offset + 1'b1;
				end
			end

			read_complete:
			begin
				// One cycle strobe returns the request and pops the load queue
				l2bi_ready = 1'b1;
				state_nxt = idle;
			end

			default:
				state_nxt = idle;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= idle;
			burst_offset <= '0;
			wait_write_response <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			burst_offset <= burst_offset_nxt;

			// Track the outstanding write response of the last burst
			if (axi_bus_req.awvalid && axi_bus_resp.awready)
				wait_write_response <= 1'b1;
			else if (axi_bus_resp.bvalid)
				wait_write_response <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == read_transfer && axi_bus_resp.rvalid)
			load_buffer[burst_offset] <= axi_bus_resp.rdata;
	end
endmodule

// ==== hw/l2_defs_pkg.sv ====
package l2_defs_pkg;
	// Cache line geometry. A 32 bit byte address splits into tag, set index and offset
	localparam int cache_line_bytes = 64;
	localparam int offset_width = 6;
	localparam int set_idx_width = 8;
	localparam int tag_width = 18;

	// System memory bus widths
	localparam int axi_addr_width = 32;
	localparam int axi_data_width = 32;
	localparam int axi_len_width = 8;

	// Number of bus beats needed to move one whole cache line
	localparam int burst_beats = cache_line_bytes * 8 / axi_data_width;
	localparam int beat_idx_width = $clog2(burst_beats);

	// Depth of the writeback and load queues, and of the pending miss table
	localparam int request_queue_length = 8;
	localparam int queue_idx_width = $clog2(request_queue_length);

	// Pipeline stages ahead of the read stage. Stall must be raised this many
	// cycles early, since packets already in those stages still arrive
	localparam int l2req_latency = 4;

	// Width of the per-line waiter count in the pending miss table
	localparam int pending_count_width = $clog2(request_queue_length + 1);

	typedef logic [tag_width - 1:0] l2_tag_t;
	typedef logic [set_idx_width - 1:0] set_idx_t;

	// A line address is the tag followed by the set index
	typedef logic [tag_width + set_idx_width - 1:0] cache_line_index_t;
	typedef logic [cache_line_bytes * 8 - 1:0] cache_line_data_t;

	typedef struct packed {
		l2_tag_t tag;
		set_idx_t set_idx;
		logic [offset_width - 1:0] offset;
	} l2_addr_t;

	typedef enum logic [2:0] {
		l2req_load,
		l2req_store,
		l2req_flush,
		l2req_load_sync,
		l2req_store_sync
	} l2req_packet_e;

	typedef struct packed {
		logic valid;
		l2req_packet_e packet_type;
		logic [3:0] id;
		l2_addr_t address;
		logic [cache_line_bytes - 1:0] store_mask;
		cache_line_data_t data;
	} l2req_packet_t;

	// Signals driven by the bus master
	typedef struct packed {
		logic [axi_addr_width - 1:0] awaddr;
		logic [axi_len_width - 1:0] awlen;
		logic awvalid;
		logic [axi_data_width - 1:0] wdata;
		logic wlast;
		logic wvalid;
		logic bready;
		logic [axi_addr_width - 1:0] araddr;
		logic [axi_len_width - 1:0] arlen;
		logic arvalid;
		logic rready;
	} axi_req_t;

	// Signals driven by the memory slave
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic arready;
		logic [axi_data_width - 1:0] rdata;
		logic rvalid;
		logic rlast;
	} axi_resp_t;
endpackage

// ==== hw/l2_miss_handler.sv ====
module l2_miss_handler
	import l2_defs_pkg::*;
	(input clk,
	input reset,

	// From the read stage
	input l2req_packet_t l2r_request,
	input logic l2r_cache_hit,
	input logic l2r_is_l2_fill,
	input logic l2r_needs_writeback,
	input l2_tag_t l2r_writeback_tag,
	input cache_line_data_t l2r_data,

	// Back to the cache pipeline
	output l2req_packet_t l2bi_request,
	output cache_line_data_t l2bi_data_from_memory,
	output logic l2bi_stall,
	output logic l2bi_ready,
	output logic l2bi_collided_miss,
	output logic perf_l2_writeback,

	// System memory
	output axi_req_t axi_bus_req,
	input axi_resp_t axi_bus_resp);

	cache_line_index_t miss_line;
	logic duplicate_request;
	logic enqueue_load_request;

	// The table tracks whole lines, so the byte offset is dropped
	assign miss_line = {l2r_request.address.tag, l2r_request.address.set_idx};

	l2_pending_miss_cam pending_miss_cam(
		.clk(clk),
		.reset(reset),
		.request_valid(l2r_request.valid),
		.request_addr(miss_line),
		.enqueue_load_request(enqueue_load_request),
		.l2r_is_l2_fill(l2r_is_l2_fill),
		.duplicate_request(duplicate_request));

	l2_axi_bus_interface bus_interface(
		.clk(clk),
		.reset(reset),
		.axi_bus_req(axi_bus_req),
		.axi_bus_resp(axi_bus_resp),
		.l2r_request(l2r_request),
		.l2r_cache_hit(l2r_cache_hit),
		.l2r_is_l2_fill(l2r_is_l2_fill),
		.l2r_needs_writeback(l2r_needs_writeback),
		.l2r_writeback_tag(l2r_writeback_tag),
		.l2r_data(l2r_data),
		.duplicate_request(duplicate_request),
		.enqueue_load_request(enqueue_load_request),
		.l2bi_request(l2bi_request),
		.l2bi_data_from_memory(l2bi_data_from_memory),
		.l2bi_stall(l2bi_stall),
		.l2bi_ready(l2bi_ready),
		.l2bi_collided_miss(l2bi_collided_miss),
		.perf_l2_writeback(perf_l2_writeback));
endmodule

// ==== hw/l2_pending_miss_cam.sv ====
module l2_pending_miss_cam
	import l2_defs_pkg::*;
	(input clk,
	input reset,
	input logic request_valid,
	input cache_line_index_t request_addr,
	input logic enqueue_load_request,
	input logic l2r_is_l2_fill,
	output logic duplicate_request);

	// One line that has a fill in flight, and how many queued misses wait for it
	typedef struct packed {
		logic valid;
		cache_line_index_t line;
		logic [pending_count_width - 1:0] waiters;
	} cam_entry_t;

	cam_entry_t entries [request_queue_length];
	logic hit;
	logic [queue_idx_width - 1:0] hit_idx;
	logic free_found;
	logic [queue_idx_width - 1:0] free_idx;

	// Search every entry for the requested line, and pick the lowest free slot
	// in the same pass
	always_comb
	begin
		hit = 1'b0;
		hit_idx = '0;
		free_found = 1'b0;
		free_idx = '0;
		for (int i = 0; i < request_queue_length; i++)
		begin
			if (entries[i].valid && entries[i].line == request_addr)
			begin
				hit = 1'b1;
				hit_idx = queue_idx_width'(i);
			end

			if (!entries[i].valid && !free_found)
			begin
				free_found = 1'b1;
				free_idx = queue_idx_width'(i);
			end
		end
	end

	// A miss to a line that is already being fetched does not need its own burst.
	// The bus interface will just hand it back to the pipeline for reissue
	assign duplicate_request = request_valid && hit;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < request_queue_length; i++)
				entries[i] <= '0;
		end
		else if (enqueue_load_request)
		begin
			if (hit)
			begin
				// Another waiter on a line that is already pending
				entries[hit_idx].waiters <= entries[hit_idx].waiters + 1'b1;
			end
			else if (free_found)
			begin
				// First miss to this line starts tracking it
				entries[free_idx].valid <= 1'b1;
				entries[free_idx].line <= request_addr;
				entries[free_idx].waiters <= pending_count_width'(1);
			end
		end
		else if (request_valid && l2r_is_l2_fill && hit)
		begin
			// Each reissued request passes the read stage as a fill.
			// The entry goes away once the last waiter has come back
			if (entries[hit_idx].waiters == pending_count_width'(1))
			begin
				entries[hit_idx].valid <= 1'b0;
				entries[hit_idx].waiters <= '0;
			end
			else
				entries[hit_idx].waiters <= entries[hit_idx].waiters - 1'b1;
		end
	end
endmodule

// ==== hw/sync_fifo.sv ====
module sync_fifo
	#(parameter int data_width = 32,
	parameter int num_entries = 8,
	parameter int almost_full_threshold = num_entries)
	(input clk,
	input reset,
	input logic flush_en,
	input logic enqueue_en,
	input [data_width - 1:0] value_i,
	input logic dequeue_en,
	output [data_width - 1:0] value_o,
	output logic empty,
	output logic full,
	output logic almost_full,
	output logic almost_empty);

	logic [data_width - 1:0] storage [num_entries];
	logic [$clog2(num_entries) - 1:0] read_ptr;
	logic [$clog2(num_entries) - 1:0] write_ptr;
	logic [$clog2(num_entries + 1) - 1:0] count;
	logic do_enqueue;
	logic do_dequeue;

	// Writes to a full queue and reads from an empty one are dropped
	assign do_enqueue = enqueue_en && !full;
	assign do_dequeue = dequeue_en && !empty;

	// The head entry is always visible, so the consumer can look before it pops
	assign value_o = storage[read_ptr];

	assign empty = count == 0;
	assign full = count == num_entries;
	assign almost_full = count >= almost_full_threshold;

	// At most one entry left
	assign almost_empty = count <= 1;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else if (flush_en)
		begin
			// Flush discards every entry at once
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap explicitly so any depth works, not only powers of two
			if (do_enqueue)
			begin
				if (int'(write_ptr) == num_entries - 1)
					write_ptr <= '0;
				else
					write_ptr <= write_ptr + 1'b1;
			end

			if (do_dequeue)
			begin
				if (int'(read_ptr) == num_entries - 1)
					read_ptr <= '0;
				else
					read_ptr <= read_ptr + 1'b1;
			end

			// Simultaneous push and pop leave the occupancy unchanged
			if (do_enqueue && !do_dequeue)
				count <= count + 1'b1;
			else if (do_dequeue && !do_enqueue)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_enqueue)
			storage[write_ptr] <= value_i;
	end
endmodule

// ==== tests/axi_memory_model.sv ====
module axi_memory_model
	import l2_defs_pkg::*;
	(input clk,
	input reset,
	input logic hold_arready,
	input axi_req_t axi_bus_req,
	output axi_resp_t axi_bus_resp,
	output int read_bursts,
	output int write_bursts);

	// Sparse word memory keyed by byte address
	logic [31:0] mem [logic [31:0]];
	logic [31:0] lcg_state;
	logic [31:0] write_addr;
	logic [31:0] read_addr;
	int write_beat;
	int read_beat;
	logic reading;

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Words that were never written read back as a mix of their address
	function automatic logic [31:0] word_hash(input logic [31:0] a);
		return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] a);
		if (mem.exists(a))
			return mem[a];
		return word_hash(a);
	endfunction

	always @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			axi_bus_resp <= '0;
			lcg_state <= 32'd77551;
			write_addr <= '0;
			read_addr <= '0;
			write_beat <= 0;
			read_beat <= 0;
			reading <= 1'b0;
			read_bursts <= 0;
			write_bursts <= 0;
		end
		else
		begin
			lcg_state <= next_random(lcg_state);

			// Each ready is high about three cycles in four
			axi_bus_resp.awready <= lcg_state[16] | lcg_state[17];
			axi_bus_resp.wready <= lcg_state[18] | lcg_state[19];
			axi_bus_resp.arready <= !hold_arready && (lcg_state[20] | lcg_state[21]);
			axi_bus_resp.bvalid <= 1'b0;

			if (axi_bus_req.awvalid && axi_bus_resp.awready)
			begin
				write_addr <= axi_bus_req.awaddr;
				write_beat <= 0;
			end

			// Beats land at consecutive word addresses from the burst base
			if (axi_bus_req.wvalid && axi_bus_resp.wready)
			begin
				mem[write_addr + 32'(4 * write_beat)] = axi_bus_req.wdata;
				write_beat <= write_beat + 1;
				if (axi_bus_req.wlast)
				begin
					axi_bus_resp.bvalid <= 1'b1;
					write_bursts <= write_bursts + 1;
				end
			end

			if (axi_bus_req.arvalid && axi_bus_resp.arready)
			begin
				read_addr <= axi_bus_req.araddr;
				read_beat <= 0;
				reading <= 1'b1;
				read_bursts <= read_bursts + 1;
			end

			// A beat stays presented until it is taken
			if (axi_bus_resp.rvalid && axi_bus_req.rready)
			begin
				axi_bus_resp.rvalid <= 1'b0;
				read_beat <= read_beat + 1;
				if (axi_bus_resp.rlast)
					reading <= 1'b0;
			end
			else if (reading && !axi_bus_resp.rvalid && lcg_state[22])
			begin
				axi_bus_resp.rvalid <= 1'b1;
				axi_bus_resp.rdata <= read_word(read_addr + 32'(4 * read_beat));
				axi_bus_resp.rlast <= read_beat == burst_beats - 1;
			end
		end
	end
endmodule

// ==== tests/l2_miss_handler_tb.sv ====
module l2_miss_handler_tb
	import l2_defs_pkg::*;
	();

	logic clk;
	logic reset;
	l2req_packet_t l2r_request;
	logic l2r_cache_hit;
	logic l2r_is_l2_fill;
	logic l2r_needs_writeback;
	l2_tag_t l2r_writeback_tag;
	cache_line_data_t l2r_data;
	l2req_packet_t l2bi_request;
	cache_line_data_t l2bi_data_from_memory;
	logic l2bi_stall;
	logic l2bi_ready;
	logic l2bi_collided_miss;
	logic perf_l2_writeback;
	axi_req_t axi_bus_req;
	axi_resp_t axi_bus_resp;
	logic hold_arready;
	int read_bursts;
	int write_bursts;

	int cycle;
	int errors;
	int tests_run;
	int tests_failed;
	int perf_count;
	int w_beat;
	logic [31:0] rand_state;

	// Everything the monitor saw, in order
	l2req_packet_t ret_packets[$];
	logic ret_collided[$];
	cache_line_data_t ret_lines[$];
	int ret_edges[$];
	logic [31:0] aw_addrs[$];
	logic [31:0] write_data[$];
	string hs_log[$];

	l2_miss_handler UUT(.*);

	axi_memory_model memory(
		.clk(clk),
		.reset(reset),
		.hold_arready(hold_arready),
		.axi_bus_req(axi_bus_req),
		.axi_bus_resp(axi_bus_resp),
		.read_bursts(read_bursts),
		.write_bursts(write_bursts));

	initial
		clk = 1'b0;

	always #4 clk = ~clk;

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Fresh memory words hold this value of their byte address
	function automatic logic [31:0] expected_word(input logic [31:0] a);
		return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
	endfunction

	// The first beat belongs in the top word of the line
	function automatic cache_line_data_t expected_line(input logic [31:0] base);
		cache_line_data_t line;
		for (int i = 0; i < burst_beats; i++)
			line[(burst_beats - 1 - i) * 32 +: 32] = expected_word(base + 32'(4 * i));
		return line;
	endfunction

	function automatic cache_line_data_t random_line();
		cache_line_data_t line;
		for (int i = 0; i < burst_beats; i++)
		begin
			rand_state = next_random(rand_state);
			line[i * 32 +: 32] = rand_state;
		end
		return line;
	endfunction

	function automatic l2req_packet_t make_packet(input l2req_packet_e kind, input logic [3:0] id,
		input l2_tag_t tag, input set_idx_t set_idx, input logic [63:0] mask);
		l2req_packet_t p;
		p = '0;
		p.valid = 1'b1;
		p.packet_type = kind;
		p.id = id;
		p.address.tag = tag;
		p.address.set_idx = set_idx;
		p.store_mask = mask;
		return p;
	endfunction

	task automatic check_value(input string name, input logic [639:0] expected,
		input logic [639:0] actual);
		assert (expected === actual)
		else
		begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_true(input string name, input logic cond, input string what);
		assert (cond)
		else
		begin
			$display("%s: %s", name, what);
			errors++;
		end
	endtask

	// Presents one packet for a single cycle. Called just after a rising edge
	task automatic send(input l2req_packet_t pkt, input logic hit, input logic fill,
		input logic wb, input l2_tag_t wb_tag, input cache_line_data_t line,
		output int sent_cycle);
		l2r_request = pkt;
		l2r_cache_hit = hit;
		l2r_is_l2_fill = fill;
		l2r_needs_writeback = wb;
		l2r_writeback_tag = wb_tag;
		l2r_data = line;
		sent_cycle = cycle;
		@(posedge clk);
		#1;
		l2r_request = '0;
		l2r_cache_hit = 1'b0;
		l2r_is_l2_fill = 1'b0;
		l2r_needs_writeback = 1'b0;
	endtask

	task automatic send_miss(input l2req_packet_t pkt);
		int unused;
		send(pkt, 1'b0, 1'b0, 1'b0, '0, '0, unused);
	endtask

	// The pipeline reissues a returned request, which passes the read stage as a fill
	task automatic reissue_fill(input l2req_packet_t pkt);
		int unused;
		send(pkt, 1'b1, 1'b1, 1'b0, '0, '0, unused);
	endtask

	task automatic wait_return(input string name, output l2req_packet_t pkt,
		output logic collided, output cache_line_data_t line, output int ret_edge);
		int waited;
		waited = 0;
		while (ret_packets.size() == 0 && waited < 4000)
		begin
			@(posedge clk);
			#1;
			waited++;
		end

		if (ret_packets.size() == 0)
		begin
			$display("%s: timed out waiting for a returned request", name);
			errors++;
			pkt = '0;
			collided = 1'bx;
			line = '0;
			ret_edge = 0;
		end
		else
		begin
			pkt = ret_packets.pop_front();
			collided = ret_collided.pop_front();
			line = ret_lines.pop_front();
			ret_edge = ret_edges.pop_front();
		end
	endtask

	task automatic wait_writes(input string name, input int target);
		int waited;
		waited = 0;
		while (write_bursts < target && waited < 4000)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		check_true(name, write_bursts >= target, "write burst never completed");
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	// Samples just before each edge settles, so values are the ones the DUT saw
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (!reset)
		begin
			if (l2bi_ready)
			begin
				ret_packets.push_back(l2bi_request);
				ret_collided.push_back(l2bi_collided_miss);
				ret_lines.push_back(l2bi_data_from_memory);
				ret_edges.push_back(cycle + 1);
			end

			// Every burst moves one whole line
			if (axi_bus_req.awvalid && axi_bus_resp.awready)
			begin
				check_value("awlen", burst_beats - 1, axi_bus_req.awlen);
				hs_log.push_back("W");
				aw_addrs.push_back(axi_bus_req.awaddr);
			end

			if (axi_bus_req.arvalid && axi_bus_resp.arready)
			begin
				check_value("arlen", burst_beats - 1, axi_bus_req.arlen);
				hs_log.push_back("R");
			end

			// The handler never refuses a write response
			if (axi_bus_resp.bvalid)
				check_true("bready", axi_bus_req.bready, "bready was low during a write response");

			// wlast must mark the sixteenth beat and no other
			if (axi_bus_req.wvalid && axi_bus_resp.wready)
			begin
				check_value("wlast", w_beat == burst_beats - 1, axi_bus_req.wlast);
				write_data.push_back(axi_bus_req.wdata);
				w_beat = axi_bus_req.wlast ? 0 : w_beat + 1;
			end

			if (perf_l2_writeback)
				perf_count++;
		end
	end

	initial
	begin
		repeat (200000) @(posedge clk);
		$display("simulation did not finish in time");
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		l2req_packet_t p1;
		l2req_packet_t p2;
		l2req_packet_t p3;
		l2req_packet_t got;
		l2req_packet_t batch[4];
		logic collided;
		cache_line_data_t line;
		cache_line_data_t wb_line;
		int ret_edge;
		int sent_cycle;
		int e0;
		int rb0;
		int wb0;
		int perf0;

		cycle = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		perf_count = 0;
		w_beat = 0;
		rand_state = 32'd77551;
		hold_arready = 1'b0;
		l2r_request = '0;
		l2r_cache_hit = 1'b0;
		l2r_is_l2_fill = 1'b0;
		l2r_needs_writeback = 1'b0;
		l2r_writeback_tag = '0;
		l2r_data = '0;
		reset = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;

		// Plain load miss
		e0 = errors;
		p1 = make_packet(l2req_load, 4'd1, 18'h00123, 8'h10, '0);
		send_miss(p1);
		wait_return("load_miss", got, collided, line, ret_edge);
		check_value("load_miss packet", p1, got);
		check_value("load_miss collided", 1'b0, collided);
		check_value("load_miss line", expected_line({18'h00123, 8'h10, 6'h0}), line);
		reissue_fill(p1);
		finish_test("load_miss", e0);

		// Eviction on a fill, then read the victim back
		e0 = errors;
		wb0 = write_bursts;
		aw_addrs.delete();
		write_data.delete();
		wb_line = random_line();
		p1 = make_packet(l2req_load, 4'd2, 18'h2aaaa, 8'h33, '0);
		send(p1, 1'b1, 1'b1, 1'b1, 18'h01555, wb_line, sent_cycle);
		wait_writes("writeback", wb0 + 1);
		check_value("writeback address", {18'h01555, 8'h33, 6'h0}, aw_addrs[0]);
		check_value("writeback beats", burst_beats, write_data.size());
		for (int i = 0; i < burst_beats && i < write_data.size(); i++)
			check_value("writeback beat", wb_line[(burst_beats - 1 - i) * 32 +: 32],
				write_data[i]);
		p2 = make_packet(l2req_load, 4'd3, 18'h01555, 8'h33, '0);
		send_miss(p2);
		wait_return("writeback", got, collided, line, ret_edge);
		check_value("writeback readback", wb_line, line);
		reissue_fill(p2);
		finish_test("writeback", e0);

		// Two misses to one line share a burst
		e0 = errors;
		rb0 = read_bursts;
		p1 = make_packet(l2req_load, 4'd4, 18'h00777, 8'h44, '0);
		p2 = make_packet(l2req_load, 4'd5, 18'h00777, 8'h44, '0);
		send_miss(p1);
		send_miss(p2);
		wait_return("collided", got, collided, line, ret_edge);
		check_value("collided first id", p1.id, got.id);
		check_value("collided first flag", 1'b0, collided);
		wait_return("collided", got, collided, line, ret_edge);
		check_value("collided second id", p2.id, got.id);
		check_value("collided second flag", 1'b1, collided);
		check_value("collided line", expected_line({18'h00777, 8'h44, 6'h0}), line);
		check_value("collided read bursts", 1, read_bursts - rb0);
		reissue_fill(p1);
		reissue_fill(p2);

		// Both waiters are back, so the line is no longer pending
		rb0 = read_bursts;
		p3 = make_packet(l2req_load, 4'd6, 18'h00777, 8'h44, '0);
		send_miss(p3);
		wait_return("collided", got, collided, line, ret_edge);
		check_value("collided refetch flag", 1'b0, collided);
		check_value("collided refetch bursts", 1, read_bursts - rb0);
		reissue_fill(p3);
		finish_test("collided", e0);

		// Full line store skips memory
		e0 = errors;
		rb0 = read_bursts;
		p1 = make_packet(l2req_store, 4'd7, 18'h00999, 8'h21, {64{1'b1}});
		p1.data = random_line();
		send(p1, 1'b0, 1'b0, 1'b0, '0, '0, sent_cycle);
		wait_return("full_store", got, collided, line, ret_edge);
		check_value("full_store latency", 2, ret_edge - (sent_cycle + 1));
		check_value("full_store packet", p1, got);
		check_value("full_store read bursts", 0, read_bursts - rb0);
		reissue_fill(p1);
		finish_test("full_store", e0);

		// Queue fills up behind a stalled read address
		e0 = errors;
		hold_arready = 1'b1;
		check_true("stall", !l2bi_stall, "stall was high before any miss was queued");
		for (int i = 0; i < 4; i++)
		begin
			batch[i] = make_packet(l2req_load, 4'(8 + i), 18'(20'h00100 + i), 8'h70, '0);
			send_miss(batch[i]);
		end
		for (int waited = 0; !l2bi_stall && waited < 20; waited++)
		begin
			@(posedge clk);
			#1;
		end
		check_true("stall", l2bi_stall, "stall did not rise with four queued misses");
		hold_arready = 1'b0;
		for (int i = 0; i < 4; i++)
		begin
			wait_return("stall", got, collided, line, ret_edge);
			check_value("stall order", batch[i].id, got.id);
			check_value("stall line", expected_line({batch[i].address.tag, 8'h70, 6'h0}), line);
		end
		for (int i = 0; i < 4; i++)
			reissue_fill(batch[i]);
		finish_test("stall", e0);

		// A writeback and a load wait together behind a stalled read address.
		// Once that read is done the writeback must go first
		e0 = errors;
		perf0 = perf_count;
		wb0 = write_bursts;
		hold_arready = 1'b1;
		p3 = make_packet(l2req_load, 4'd14, 18'h00246, 8'h19, '0);
		p1 = make_packet(l2req_load, 4'd12, 18'h3c3c3, 8'h5a, '0);
		p2 = make_packet(l2req_load, 4'd13, 18'h0f0f0, 8'h66, '0);
		send_miss(p3);
		send(p1, 1'b1, 1'b1, 1'b1, 18'h00abc, random_line(), sent_cycle);
		send_miss(p2);
		hold_arready = 1'b0;
		wait_return("priority", got, collided, line, ret_edge);
		check_value("priority first id", p3.id, got.id);
		hs_log.delete();
		wait_return("priority", got, collided, line, ret_edge);
		wait_writes("priority", wb0 + 1);
		check_value("priority id", p2.id, got.id);
		check_value("priority line", expected_line({18'h0f0f0, 8'h66, 6'h0}), line);
		check_true("priority", hs_log.size() >= 2, "missing address handshakes");
		if (hs_log.size() >= 2)
			check_true("priority", hs_log[0] == "W" && hs_log[1] == "R",
				"read address was accepted before the write address");
		check_value("priority perf count", 1, perf_count - perf0);
		reissue_fill(p3);
		reissue_fill(p2);
		finish_test("priority", e0);

		$display("tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end
endmodule
